// File: include/dll_mon_defines.svh
`ifndef DLL_MON_DEFINES_SVH
`define DLL_MON_DEFINES_SVH

// ==============================
// Field widths
// ==============================
`define DLL_SEQ_W          12
`define DLL_HDR_CR_W       8
`define DLL_DATA_CR_W      12
`define DLL_LEN_W          10
`define DLL_NUM_FC         3
`define DLL_ERR_W          6
`define DLL_ERR_CNT_W      8

// Count holds here once reached
`define DLL_ERR_CNT_MAX    8'hFF

// ==============================
// DLLP type encodings
// ==============================
`define DLL_T_ACK          8'h00
`define DLL_T_NAK          8'h10
`define DLL_T_INITFC1_P    8'h40
`define DLL_T_INITFC1_NP   8'h50
`define DLL_T_INITFC1_CPL  8'h60
`define DLL_T_INITFC2_P    8'h48
`define DLL_T_INITFC2_NP   8'h58
`define DLL_T_INITFC2_CPL  8'h68
`define DLL_T_UPDATEFC_P   8'h80
`define DLL_T_UPDATEFC_NP  8'h90
`define DLL_T_UPDATEFC_CPL 8'hA0
`define DLL_T_PM_ENTER_L1  8'h20
`define DLL_T_PM_ENTER_L23 8'h21
`define DLL_T_PM_REQ_L1    8'h24
`define DLL_T_PM_REQ_ACK   8'h25

// Error vector bit positions, credit bits follow class order
`define DLL_ERR_DLLP_TYPE  0
`define DLL_ERR_INIT_ORDER 1
`define DLL_ERR_SEQ        2
`define DLL_ERR_CREDIT_P   3

`endif

// File: logic/dll_mon_pkg.sv
`include "dll_mon_defines.svh"

package dll_mon_pkg;

    // ==============================
    // Flow-control classes
    // ==============================
    // Value doubles as index into per-class arrays
    typedef enum logic [1:0] {
        FC_P   = 2'd0,
        FC_NP  = 2'd1,
        FC_CPL = 2'd2
    } fc_class_e;

    // ==============================
    // Link-side payloads
    // ==============================
    // Accepted TLP as seen on the transmit side
    typedef struct packed {
        logic [`DLL_SEQ_W-1:0] seq_num;
        fc_class_e             fc_class;
        // Zero means 1024 DW
        logic [`DLL_LEN_W-1:0] length;
        // Retransmitted copy, exempt from sequence check
        logic                  replay;
    } tlp_info_t;

    // Received DLLP, CRC already stripped
    typedef struct packed {
        logic [7:0]                dllp_type;
        logic [`DLL_HDR_CR_W-1:0]  hdr_credits;
        logic [`DLL_DATA_CR_W-1:0] data_credits;
    } dllp_t;

    // Per-class event from decoder to one credit checker
    typedef struct packed {
        logic                      init1;
        logic                      update;
        logic [`DLL_HDR_CR_W-1:0]  hdr_credits;
        logic [`DLL_DATA_CR_W-1:0] data_credits;
        logic                      tlp;
        // Data credits this TLP needs, 16 bytes each
        logic [`DLL_DATA_CR_W-1:0] data_need;
    } fc_event_t;

    // Violation bits, LSB first from dllp_type
    typedef struct packed {
        logic credit_cpl;
        logic credit_np;
        logic credit_p;
        logic seq;
        logic init_order;
        logic dllp_type;
    } err_vec_t;

endpackage

// File: logic/dllp_decode.sv
`timescale 1ns/10ps
`include "dll_mon_defines.svh"

module dllp_decode (
    input  logic                   pclk,
    input  logic                   reset_n,
    input  logic                   tlp_valid,
    input  dll_mon_pkg::tlp_info_t tlp,
    input  logic                   dllp_valid,
    input  dll_mon_pkg::dllp_t     dllp,
    output dll_mon_pkg::fc_event_t fc_ev [`DLL_NUM_FC],
    output logic                   seq_valid,
    output dll_mon_pkg::tlp_info_t seq_ev,
    output dll_mon_pkg::err_vec_t  dec_err,
    output logic                   fc_init1_done,
    output logic                   dl_up
);
    import dll_mon_pkg::*;

    // Rounding and max-payload constants for data credits
    localparam logic [`DLL_DATA_CR_W-1:0] ROUND_UP       = 3;
    localparam logic [`DLL_DATA_CR_W-1:0] MAX_PAYLOAD_CR = 256;

    fc_event_t                 fc_ev_d [`DLL_NUM_FC];
    logic [`DLL_NUM_FC-1:0]    init1_hit;
    logic [`DLL_NUM_FC-1:0]    init2_hit;
    logic [`DLL_NUM_FC-1:0]    upd_hit;
    logic [`DLL_NUM_FC-1:0]    init1_seen;
    logic [`DLL_NUM_FC-1:0]    init2_seen;
    logic                      type_ok;
    logic                      type_bad_q;
    logic                      order_bad_q;
    logic [`DLL_DATA_CR_W-1:0] len_ext;
    logic [`DLL_DATA_CR_W-1:0] data_need;

    // ==============================
    // DLLP type decode
    // ==============================
    always_comb begin
        init1_hit = '0;
        init2_hit = '0;
        upd_hit   = '0;
        type_ok   = 1'b1;
        case (dllp.dllp_type)
            `DLL_T_INITFC1_P:   init1_hit[FC_P]   = 1'b1;
            `DLL_T_INITFC1_NP:  init1_hit[FC_NP]  = 1'b1;
            `DLL_T_INITFC1_CPL: init1_hit[FC_CPL] = 1'b1;
            `DLL_T_INITFC2_P:   init2_hit[FC_P]   = 1'b1;
            `DLL_T_INITFC2_NP:  init2_hit[FC_NP]  = 1'b1;
            `DLL_T_INITFC2_CPL: init2_hit[FC_CPL] = 1'b1;
            `DLL_T_UPDATEFC_P:   upd_hit[FC_P]    = 1'b1;
            `DLL_T_UPDATEFC_NP:  upd_hit[FC_NP]   = 1'b1;
            `DLL_T_UPDATEFC_CPL: upd_hit[FC_CPL]  = 1'b1;
            // Legal but no effect on credit state
            `DLL_T_ACK, `DLL_T_NAK,
            `DLL_T_PM_ENTER_L1, `DLL_T_PM_ENTER_L23,
            `DLL_T_PM_REQ_L1, `DLL_T_PM_REQ_ACK: type_ok = 1'b1;
            default: type_ok = 1'b0;
        endcase
    end

    // Ceiling of length/4, zero length is a full 1024 DW
    assign len_ext   = {{(`DLL_DATA_CR_W - `DLL_LEN_W){1'b0}}, tlp.length};
    assign data_need = (tlp.length == '0) ? MAX_PAYLOAD_CR : ((len_ext + ROUND_UP) >> 2);

    // Steer to the class the event belongs to
    always_comb begin
        for (int i = 0; i < `DLL_NUM_FC; i++) begin
            fc_ev_d[i].init1        = dllp_valid && init1_hit[i];
            fc_ev_d[i].update       = dllp_valid && upd_hit[i];
            fc_ev_d[i].hdr_credits  = dllp.hdr_credits;
            fc_ev_d[i].data_credits = dllp.data_credits;
            fc_ev_d[i].tlp          = tlp_valid && (tlp.fc_class == fc_class_e'(i));
            fc_ev_d[i].data_need    = data_need;
        end
    end

    // ==============================
    // Event stage
    // ==============================
    always_ff @(posedge pclk) begin
        fc_ev  <= fc_ev_d;
        seq_ev <= tlp;
        // Only the strobes are cleared
        if (!reset_n) begin
            for (int i = 0; i < `DLL_NUM_FC; i++) begin
                fc_ev[i].init1  <= 1'b0;
                fc_ev[i].update <= 1'b0;
                fc_ev[i].tlp    <= 1'b0;
            end
            seq_valid <= 1'b0;
        end else begin
            seq_valid <= tlp_valid;
        end
    end

    // ==============================
    // Init tracking
    // ==============================
    always_ff @(posedge pclk) begin
        if (!reset_n) begin
            init1_seen <= '0;
            init2_seen <= '0;
        end else if (dllp_valid) begin
            init1_seen <= init1_seen | init1_hit;
            // InitFC2 only counts once all InitFC1 are in
            if (fc_init1_done) begin
                init2_seen <= init2_seen | init2_hit;
            end
        end
    end

    assign fc_init1_done = &init1_seen;
    assign dl_up         = &init2_seen;

    // Own violations take two stages to line up with the checkers
    always_ff @(posedge pclk) begin
        if (!reset_n) begin
            type_bad_q  <= 1'b0;
            order_bad_q <= 1'b0;
            dec_err     <= '0;
        end else begin
            type_bad_q  <= dllp_valid && !type_ok;
            order_bad_q <= dllp_valid && (|init2_hit) && !fc_init1_done;
            dec_err            <= '0;
            dec_err.dllp_type  <= type_bad_q;
            dec_err.init_order <= order_bad_q;
        end
    end

endmodule

// File: logic/fc_credit_check.sv
`timescale 1ns/10ps
`include "dll_mon_defines.svh"

module fc_credit_check (
    input  logic                   pclk,
    input  logic                   reset_n,
    input  dll_mon_pkg::fc_event_t ev,
    output logic                   credit_err
);

    localparam logic [`DLL_HDR_CR_W-1:0] ONE_HDR = 1;

    // ==============================
    // Credit state for one class
    // ==============================
    // Limits as advertised by the receiver
    logic [`DLL_HDR_CR_W-1:0]  hdr_limit;
    logic [`DLL_DATA_CR_W-1:0] data_limit;
    // Consumed totals, modular like the limits
    logic [`DLL_HDR_CR_W-1:0]  hdr_used;
    logic [`DLL_DATA_CR_W-1:0] data_used;
    // Remaining credit before this cycle's update
    logic [`DLL_HDR_CR_W-1:0]  hdr_avail;
    logic [`DLL_DATA_CR_W-1:0] data_avail;
    logic                      short_cr;

    assign hdr_avail  = hdr_limit - hdr_used;
    assign data_avail = data_limit - data_used;

    // One header credit per TLP, data per payload size
    assign short_cr = (hdr_avail == '0) || (data_avail < ev.data_need);

    // Limit update from InitFC1 or UpdateFC
    always_ff @(posedge pclk) begin
        if (!reset_n) begin
            hdr_limit  <= '0;
            data_limit <= '0;
        end else if (ev.init1 || ev.update) begin
            hdr_limit  <= ev.hdr_credits;
            data_limit <= ev.data_credits;
        end
    end

    // ==============================
    // Consumption
    // ==============================
    // Rejected TLP leaves counters untouched
    always_ff @(posedge pclk) begin
        if (!reset_n) begin
            hdr_used  <= '0;
            data_used <= '0;
        end else if (ev.tlp && !short_cr) begin
            hdr_used  <= hdr_used + ONE_HDR;
            data_used <= data_used + ev.data_need;
        end
    end

    // Violation pulse, one cycle per bad TLP
    always_ff @(posedge pclk) begin
        if (!reset_n) begin
            credit_err <= 1'b0;
        end else begin
            credit_err <= ev.tlp && short_cr;
        end
    end

endmodule

// File: logic/seq_num_check.sv
`timescale 1ns/10ps
`include "dll_mon_defines.svh"

module seq_num_check (
    input  logic                   pclk,
    input  logic                   reset_n,
    input  logic                   seq_valid,
    input  dll_mon_pkg::tlp_info_t seq_ev,
    output logic                   seq_err
);

    localparam logic [`DLL_SEQ_W-1:0] SEQ_STEP = 1;

    // ==============================
    // Expected sequence number
    // ==============================
    logic [`DLL_SEQ_W-1:0] seq_exp;
    // Fresh TLP, replays are exempt
    logic                  seq_new;
    logic                  seq_miss;

    assign seq_new  = seq_valid && !seq_ev.replay;
    assign seq_miss = seq_ev.seq_num != seq_exp;

    // Resync to received number plus one, wraps 4095 to 0
    always_ff @(posedge pclk) begin
        if (!reset_n) begin
            seq_exp <= '0;
        end else if (seq_new) begin
            seq_exp <= seq_ev.seq_num + SEQ_STEP;
        end
    end

    // Pulse on a break in continuity
    always_ff @(posedge pclk) begin
        if (!reset_n) begin
            seq_err <= 1'b0;
        end else begin
            seq_err <= seq_new && seq_miss;
        end
    end

endmodule

// File: logic/dll_err_collect.sv
`timescale 1ns/10ps
`include "dll_mon_defines.svh"

module dll_err_collect (
    input  logic                       pclk,
    input  logic                       reset_n,
    input  dll_mon_pkg::err_vec_t      err_in,
    input  logic                       err_clear,
    output dll_mon_pkg::err_vec_t      err_sticky,
    output logic [`DLL_ERR_CNT_W-1:0]  err_count,
    output logic                       err_any
);
    import dll_mon_pkg::*;

    localparam logic [`DLL_ERR_CNT_W-1:0] CNT_STEP = 1;

    // Any violation this cycle
    logic hit;
    // Counter at its ceiling
    logic cnt_full;

    assign hit      = |err_in;
    assign cnt_full = err_count == `DLL_ERR_CNT_MAX;

    // ==============================
    // Sticky bits
    // ==============================
    // Clear drops old bits while new arrivals still land
    always_ff @(posedge pclk) begin
        if (!reset_n) begin
            err_sticky <= '0;
        end else if (err_clear) begin
            err_sticky <= err_in;
        end else begin
            err_sticky <= err_vec_t'(err_sticky | err_in);
        end
    end

    // ==============================
    // Violation cycle count
    // ==============================
    // Several bits in one cycle count once
    always_ff @(posedge pclk) begin
        if (!reset_n) begin
            err_count <= '0;
        end else if (err_clear) begin
            err_count <= {{(`DLL_ERR_CNT_W-1){1'b0}}, hit};
        end else if (hit && !cnt_full) begin
            err_count <= err_count + CNT_STEP;
        end
    end

    assign err_any = |err_sticky;

endmodule

// File: logic/dll_monitor_top.sv
`timescale 1ns/10ps
`include "dll_mon_defines.svh"

module dll_monitor_top (
    input  logic                      pclk,
    input  logic                      reset_n,
    input  logic                      tlp_valid,
    input  dll_mon_pkg::tlp_info_t    tlp,
    input  logic                      dllp_valid,
    input  dll_mon_pkg::dllp_t        dllp,
    input  logic                      err_clear,
    output dll_mon_pkg::err_vec_t     err_sticky,
    output logic [`DLL_ERR_CNT_W-1:0] err_count,
    output logic                      err_any,
    output logic                      fc_init1_done,
    output logic                      dl_up
);
    import dll_mon_pkg::*;

    // ==============================
    // Internal wiring
    // ==============================
    fc_event_t              fc_ev [`DLL_NUM_FC];
    logic                   seq_valid;
    tlp_info_t              seq_ev;
    err_vec_t               dec_err;
    logic [`DLL_NUM_FC-1:0] credit_err;
    logic                   seq_err;
    logic [`DLL_ERR_W-1:0]  err_bits;
    err_vec_t               err_in;

    // Decoder, first stage
    dllp_decode u_decode (
        .pclk          (pclk),
        .reset_n       (reset_n),
        .tlp_valid     (tlp_valid),
        .tlp           (tlp),
        .dllp_valid    (dllp_valid),
        .dllp          (dllp),
        .fc_ev         (fc_ev),
        .seq_valid     (seq_valid),
        .seq_ev        (seq_ev),
        .dec_err       (dec_err),
        .fc_init1_done (fc_init1_done),
        .dl_up         (dl_up)
    );

    // One credit checker per class
    for (genvar g = 0; g < `DLL_NUM_FC; g++) begin : g_fc
        fc_credit_check u_credit (
            .pclk       (pclk),
            .reset_n    (reset_n),
            .ev         (fc_ev[g]),
            .credit_err (credit_err[g])
        );
    end

    seq_num_check u_seq (
        .pclk      (pclk),
        .reset_n   (reset_n),
        .seq_valid (seq_valid),
        .seq_ev    (seq_ev),
        .seq_err   (seq_err)
    );

    // Gather violation bits in error vector order
    assign err_bits[`DLL_ERR_DLLP_TYPE]               = dec_err.dllp_type;
    assign err_bits[`DLL_ERR_INIT_ORDER]              = dec_err.init_order;
    assign err_bits[`DLL_ERR_SEQ]                     = seq_err;
    assign err_bits[`DLL_ERR_CREDIT_P +: `DLL_NUM_FC] = credit_err;
    assign err_in = err_vec_t'(err_bits);

    dll_err_collect u_collect (
        .pclk       (pclk),
        .reset_n    (reset_n),
        .err_in     (err_in),
        .err_clear  (err_clear),
        .err_sticky (err_sticky),
        .err_count  (err_count),
        .err_any    (err_any)
    );

endmodule

// File: tests/dll_monitor_chk.sv
`timescale 1ns/10ps
`include "dll_mon_defines.svh"

module dll_monitor_chk (
    input logic                      pclk,
    input logic                      reset_n,
    input logic                      err_clear,
    input dll_mon_pkg::err_vec_t     err_sticky,
    input logic [`DLL_ERR_CNT_W-1:0] err_count,
    input logic                      fc_init1_done,
    input logic                      dl_up
);

    // ==============================
    // Collector behavior
    // ==============================
    // Sticky bits only ever rise unless a clear was sampled
    sticky_hold: assert property (@(posedge pclk) disable iff (!reset_n)
        !$past(err_clear) |-> ((err_sticky & $past(err_sticky)) == $past(err_sticky)))
        else $error("Sticky error bit fell without a clear");

    // Count is monotonic between clears
    count_hold: assert property (@(posedge pclk) disable iff (!reset_n)
        !$past(err_clear) |-> (err_count >= $past(err_count)))
        else $error("Error count decreased without a clear");

    // ==============================
    // Init state
    // ==============================
    // Link cannot be up before all InitFC1 are in
    up_after_init1: assert property (@(posedge pclk) disable iff (!reset_n)
        dl_up |-> fc_init1_done)
        else $error("dl_up high while fc_init1_done is low");

endmodule

// File: tests/dll_monitor_tb.sv
`timescale 1ns/10ps
`include "dll_mon_defines.svh"

module dll_monitor_tb;
    import dll_mon_pkg::*;

    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] LFSR_SEED  = 32'h6d2f_c305;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam logic [7:0]  LEGAL_CODES [15] = '{
        `DLL_T_ACK, `DLL_T_NAK, `DLL_T_INITFC1_P, `DLL_T_INITFC1_NP,
        `DLL_T_INITFC1_CPL, `DLL_T_INITFC2_P, `DLL_T_INITFC2_NP,
        `DLL_T_INITFC2_CPL, `DLL_T_UPDATEFC_P, `DLL_T_UPDATEFC_NP,
        `DLL_T_UPDATEFC_CPL, `DLL_T_PM_ENTER_L1, `DLL_T_PM_ENTER_L23,
        `DLL_T_PM_REQ_L1, `DLL_T_PM_REQ_ACK
    };

    typedef enum logic [1:0] {K_TLP, K_DLLP, K_CLEAR, K_IDLE} row_kind_e;

    // One table entry with stimulus and expected outputs after the row
    typedef struct packed {
        row_kind_e                 kind;
        tlp_info_t                 tlp;
        dllp_t                     dllp;
        // Back-to-back repeats of the same strobe
        logic [15:0]               reps;
        err_vec_t                  exp_sticky;
        logic [`DLL_ERR_CNT_W-1:0] exp_count;
        logic                      exp_init1;
        logic                      exp_up;
    } row_t;

    logic                      pclk;
    logic                      reset_n;
    logic                      tlp_valid;
    tlp_info_t                 tlp;
    logic                      dllp_valid;
    dllp_t                     dllp;
    logic                      err_clear;
    err_vec_t                  err_sticky;
    logic [`DLL_ERR_CNT_W-1:0] err_count;
    logic                      err_any;
    logic                      fc_init1_done;
    logic                      dl_up;

    row_t        rows [$];
    int          init_rows;
    int          row_idx;
    int          errors;
    int          checks;
    logic [31:0] lfsr;

    dll_monitor_top uut (
        .pclk          (pclk),
        .reset_n       (reset_n),
        .tlp_valid     (tlp_valid),
        .tlp           (tlp),
        .dllp_valid    (dllp_valid),
        .dllp          (dllp),
        .err_clear     (err_clear),
        .err_sticky    (err_sticky),
        .err_count     (err_count),
        .err_any       (err_any),
        .fc_init1_done (fc_init1_done),
        .dl_up         (dl_up)
    );

    bind dll_monitor_top dll_monitor_chk u_chk (
        .pclk          (pclk),
        .reset_n       (reset_n),
        .err_clear     (err_clear),
        .err_sticky    (err_sticky),
        .err_count     (err_count),
        .fc_init1_done (fc_init1_done),
        .dl_up         (dl_up)
    );

    // 8 ns clock
    initial begin
        pclk = 1'b0;
        forever #4 pclk = ~pclk;
    end

    // ==============================
    // Table entry builders
    // ==============================
    task automatic tlp_row(input logic [`DLL_SEQ_W-1:0] seq, input fc_class_e cls,
                           input logic [`DLL_LEN_W-1:0] len, input logic replay,
                           input err_vec_t sticky, input logic [7:0] cnt,
                           input logic i1, input logic up);
        row_t r;
        r = '0;
        r.kind         = K_TLP;
        r.tlp.seq_num  = seq;
        r.tlp.fc_class = cls;
        r.tlp.length   = len;
        r.tlp.replay   = replay;
        r.reps         = 16'd1;
        r.exp_sticky   = sticky;
        r.exp_count    = cnt;
        r.exp_init1    = i1;
        r.exp_up       = up;
        rows.push_back(r);
    endtask

    task automatic dllp_row(input logic [7:0] code, input logic [7:0] hdr,
                            input logic [11:0] data, input logic [15:0] reps,
                            input err_vec_t sticky, input logic [7:0] cnt,
                            input logic i1, input logic up);
        row_t r;
        r = '0;
        r.kind              = K_DLLP;
        r.dllp.dllp_type    = code;
        r.dllp.hdr_credits  = hdr;
        r.dllp.data_credits = data;
        r.reps              = reps;
        r.exp_sticky        = sticky;
        r.exp_count         = cnt;
        r.exp_init1         = i1;
        r.exp_up            = up;
        rows.push_back(r);
    endtask

    // A clear always leaves sticky bits and count at zero
    task automatic clear_row(input logic i1, input logic up);
        row_t r;
        r = '0;
        r.kind      = K_CLEAR;
        r.reps      = 16'd1;
        r.exp_init1 = i1;
        r.exp_up    = up;
        rows.push_back(r);
    endtask

    task automatic idle_row(input err_vec_t sticky, input logic [7:0] cnt,
                            input logic i1, input logic up);
        row_t r;
        r = '0;
        r.kind       = K_IDLE;
        r.reps       = 16'd1;
        r.exp_sticky = sticky;
        r.exp_count  = cnt;
        r.exp_init1  = i1;
        r.exp_up     = up;
        rows.push_back(r);
    endtask

    // ==============================
    // Stimulus table
    // ==============================
    task automatic build_table();
        // Outputs quiet out of reset
        idle_row(6'h00, 8'd0, 1'b0, 1'b0);
        // InitFC2 before any InitFC1 is out of order
        dllp_row(`DLL_T_INITFC2_P, 8'd0, 12'd0, 16'd1, 6'h02, 8'd1, 1'b0, 1'b0);
        clear_row(1'b0, 1'b0);
        // Limits P 2/4, NP 1/1, CPL 1/64
        dllp_row(`DLL_T_INITFC1_P, 8'd2, 12'd4, 16'd1, 6'h00, 8'd0, 1'b0, 1'b0);
        dllp_row(`DLL_T_INITFC1_NP, 8'd1, 12'd1, 16'd1, 6'h00, 8'd0, 1'b0, 1'b0);
        dllp_row(`DLL_T_INITFC1_CPL, 8'd1, 12'd64, 16'd1, 6'h00, 8'd0, 1'b1, 1'b0);
        dllp_row(`DLL_T_INITFC2_P, 8'd0, 12'd0, 16'd1, 6'h00, 8'd0, 1'b1, 1'b0);
        dllp_row(`DLL_T_INITFC2_NP, 8'd0, 12'd0, 16'd1, 6'h00, 8'd0, 1'b1, 1'b0);
        dllp_row(`DLL_T_INITFC2_CPL, 8'd0, 12'd0, 16'd1, 6'h00, 8'd0, 1'b1, 1'b1);
        init_rows = rows.size();

        // P class 8 DW takes 2 credits and 12 DW needs 3 of 2 left
        tlp_row(12'd0, FC_P, 10'd8, 1'b0, 6'h00, 8'd0, 1'b1, 1'b1);
        tlp_row(12'd1, FC_P, 10'd12, 1'b0, 6'h08, 8'd1, 1'b1, 1'b1);
        dllp_row(`DLL_T_UPDATEFC_P, 8'd4, 12'd8, 16'd1, 6'h08, 8'd1, 1'b1, 1'b1);
        tlp_row(12'd2, FC_P, 10'd12, 1'b0, 6'h08, 8'd1, 1'b1, 1'b1);
        // NP class runs out of header credit
        tlp_row(12'd3, FC_NP, 10'd1, 1'b0, 6'h08, 8'd1, 1'b1, 1'b1);
        tlp_row(12'd4, FC_NP, 10'd1, 1'b0, 6'h18, 8'd2, 1'b1, 1'b1);
        dllp_row(`DLL_T_UPDATEFC_NP, 8'd2, 12'd2, 16'd1, 6'h18, 8'd2, 1'b1, 1'b1);
        tlp_row(12'd5, FC_NP, 10'd1, 1'b0, 6'h18, 8'd2, 1'b1, 1'b1);
        // Zero-length CPL needs 256 data credits
        tlp_row(12'd6, FC_CPL, 10'd0, 1'b0, 6'h38, 8'd3, 1'b1, 1'b1);
        dllp_row(`DLL_T_UPDATEFC_CPL, 8'd8, 12'd300, 16'd1, 6'h38, 8'd3, 1'b1, 1'b1);
        tlp_row(12'd7, FC_CPL, 10'd0, 1'b0, 6'h38, 8'd3, 1'b1, 1'b1);
        tlp_row(12'd8, FC_CPL, 10'd5, 1'b0, 6'h38, 8'd3, 1'b1, 1'b1);
        clear_row(1'b1, 1'b1);

        // Undefined type then every legal one
        dllp_row(8'h33, 8'd0, 12'd0, 16'd1, 6'h01, 8'd1, 1'b1, 1'b1);
        clear_row(1'b1, 1'b1);
        for (int i = 0; i < 15; i++) begin
            dllp_row(LEGAL_CODES[i], 8'h80, 12'h800, 16'd1, 6'h00, 8'd0, 1'b1, 1'b1);
        end

        // Replay of an old number is exempt from the sequence check
        tlp_row(12'd9, FC_P, 10'd1, 1'b0, 6'h00, 8'd0, 1'b1, 1'b1);
        tlp_row(12'd3, FC_P, 10'd1, 1'b1, 6'h00, 8'd0, 1'b1, 1'b1);
        tlp_row(12'd12, FC_P, 10'd1, 1'b0, 6'h04, 8'd1, 1'b1, 1'b1);
        clear_row(1'b1, 1'b1);
        // Jump near the top resyncs, then wrap through 4095
        tlp_row(12'd4094, FC_P, 10'd1, 1'b0, 6'h04, 8'd1, 1'b1, 1'b1);
        clear_row(1'b1, 1'b1);
        tlp_row(12'd4095, FC_P, 10'd1, 1'b0, 6'h00, 8'd0, 1'b1, 1'b1);
        tlp_row(12'd0, FC_P, 10'd1, 1'b0, 6'h00, 8'd0, 1'b1, 1'b1);

        // NP header exhausted and a skipped number in the same cycle
        dllp_row(`DLL_T_UPDATEFC_NP, 8'd2, 12'h800, 16'd1, 6'h00, 8'd0, 1'b1, 1'b1);
        tlp_row(12'd5, FC_NP, 10'd1, 1'b0, 6'h14, 8'd1, 1'b1, 1'b1);
        // 300 bad DLLPs saturate the count at 255
        dllp_row(8'hFF, 8'd0, 12'd0, 16'd300, 6'h15, 8'hFF, 1'b1, 1'b1);
        clear_row(1'b1, 1'b1);
    endtask

    // ==============================
    // Drive and compare
    // ==============================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // 0 to 3 idle cycles from two LFSR bits
    task automatic idle_gap();
        int gap;
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_next(lfsr);
            gap  = gap * 2 + int'(lfsr[0]);
        end
        repeat (gap) @(posedge pclk);
    endtask

    task automatic apply_row(input row_t r);
        int n;
        n = (r.reps == 16'd0) ? 1 : int'(r.reps);
        @(posedge pclk);
        #1;
        case (r.kind)
            K_TLP: begin
                tlp       = r.tlp;
                tlp_valid = 1'b1;
            end
            K_DLLP: begin
                dllp       = r.dllp;
                dllp_valid = 1'b1;
            end
            K_CLEAR: err_clear = 1'b1;
            default: ;
        endcase
        repeat (n) @(posedge pclk);
        #1;
        tlp_valid  = 1'b0;
        dllp_valid = 1'b0;
        err_clear  = 1'b0;
        // Pipeline drains in three cycles
        repeat (3) @(posedge pclk);
        #1;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%0h expected 0x%0h at row %0d",
                     name, got, exp, row_idx);
        end
    endtask

    task automatic check_row(input row_t r);
        check_val("err_sticky", 32'(err_sticky), 32'(r.exp_sticky));
        check_val("err_count", 32'(err_count), 32'(r.exp_count));
        check_val("err_any", 32'(err_any), 32'(|r.exp_sticky));
        check_val("fc_init1_done", 32'(fc_init1_done), 32'(r.exp_init1));
        check_val("dl_up", 32'(dl_up), 32'(r.exp_up));
    endtask

    task automatic wait_dl_up();
        int cyc;
        cyc = 0;
        while (!dl_up && cyc < WAIT_LIMIT) begin
            @(posedge pclk);
            cyc++;
        end
        if (!dl_up) begin
            errors++;
            $display("Timed out after %0d cycles waiting for dl_up", WAIT_LIMIT);
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        reset_n    = 1'b0;
        tlp_valid  = 1'b0;
        tlp        = '0;
        dllp_valid = 1'b0;
        dllp       = '0;
        err_clear  = 1'b0;
        errors     = 0;
        checks     = 0;
        row_idx    = 0;
        lfsr       = LFSR_SEED;
        build_table();

        // Ten cycles of reset
        repeat (10) @(posedge pclk);
        #1;
        reset_n = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            row_idx = i;
            apply_row(rows[i]);
            check_row(rows[i]);
            // Link must be up before credit traffic
            if (i == init_rows - 1) begin
                wait_dl_up();
            end
            idle_gap();
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
logic/dll_mon_pkg.sv
logic/dllp_decode.sv
logic/fc_credit_check.sv
logic/seq_num_check.sv
logic/dll_err_collect.sv
logic/dll_monitor_top.sv
tests/dll_monitor_chk.sv
tests/dll_monitor_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := dll_monitor_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
